// File: files.f
rv_pkg.sv
rv_pipe_reg.sv
rv_decoder.sv
rv_regfile.sv
rv_hazard_unit.sv
rv_execute.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the core with its testbench in Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
fail_msg="Done: errors found"
pass_msg="Done: no errors"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rv_core -f files.f -o tb_rv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Assertion errors must not stop the run before the testbench reports
./obj_dir/tb_rv_core_sim +verilator+error+limit+100 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$fail_msg" "$log_file"; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -qx "$pass_msg" "$log_file"; then
  echo "Simulation ended without a result line"
  exit 1
fi
echo "Simulation passed"
exit 0

// File: rv_patterns.txt
# I <instruction word, hex> <test name> <assembly>
# S <store address, hex> <store data, hex> <test name>
I FFB00093 fwd_chain addi x1,x0,-5
I 00C08113 fwd_chain addi x2,x1,12
I 401101B3 fwd_chain sub x3,x2,x1
I 00302023 fwd_chain sw x3,0(x0)
S 00000000 0000000C fwd_chain
I 80000237 shift_xor lui x4,0x80000
I 402252B3 shift_xor sra x5,x4,x2
I 00225333 shift_xor srl x6,x4,x2
I 0062C3B3 shift_xor xor x7,x5,x6
I 00702223 shift_xor sw x7,4(x0)
S 00000004 FE000000 shift_xor
I 0020A433 compare_logic slt x8,x1,x2
I 001134B3 compare_logic sltu x9,x2,x1
I 00241533 compare_logic sll x10,x8,x2
I 009565B3 compare_logic or x11,x10,x9
I 0F15F613 compare_logic andi x12,x11,0xf1
I 00C02423 compare_logic sw x12,8(x0)
S 00000008 00000081 compare_logic
I 00402683 load_use lw x13,4(x0)
I 00168713 load_use addi x14,x13,1
I 00E02623 load_use sw x14,12(x0)
S 0000000C FE000001 load_use
I 06300013 x0_write addi x0,x0,99
I 00002823 x0_write sw x0,16(x0)
S 00000010 00000000 x0_write
I 00310A63 not_taken beq x2,x3,+20
I 00319863 not_taken bne x3,x3,+16
I 00114663 not_taken blt x2,x1,+12
I 0020D463 not_taken bge x1,x2,+8
I 00202A23 not_taken sw x2,20(x0)
S 00000014 00000007 not_taken
I 00311663 taken_bne bne x2,x3,+12
I 00102E23 shadow sw x1,28(x0)
I 00102E23 shadow sw x1,28(x0)
I 0020C463 taken_blt blt x1,x2,+8
I 00102E23 shadow sw x1,28(x0)
I 00115463 taken_bge bge x2,x1,+8
I 00102E23 shadow sw x1,28(x0)
I 00318463 taken_beq beq x3,x3,+8
I 00102E23 shadow sw x1,28(x0)
I 00102C23 taken_target sw x1,24(x0)
S 00000018 FFFFFFFB taken_target
I 00000063 halt beq x0,x0,0

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          imem_words   = 256;
  localparam int          dmem_words   = 64;
  localparam int          drain_cycles = 12;  // Time left for a surplus store to show up
  localparam logic [31:0] nop_word     = 32'h0000_0013;

  typedef struct packed {
    logic [31:0]     addr;
    logic [31:0]     data;
    logic [8*24-1:0] test_name;
  } store_rec_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic [31:0] instr_data;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;
  logic        data_we;

  logic [31:0] imem [imem_words];
  logic [31:0] dmem [dmem_words];

  store_rec_t expected [$];
  int         prog_words   = 0;
  int         stores_seen  = 0;
  int         load_errors  = 0;
  int         reset_errors = 0;
  int         store_errors = 0;
  bit         timed_out    = 1'b0;

  rv_core UUT (
    .clk(clk), .rst_n(rst_n), .instr_addr(instr_addr), .instr_data(instr_data),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
    .data_rdata(data_rdata)
  );

  // ####################################################################
  // Clock and memory models
  // ####################################################################
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  assign instr_data = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[7:2]];

  always @(posedge clk) begin
    if (data_we) dmem[data_addr[7:2]] <= data_wdata;
  end

  // ####################################################################
  // Patterns, store checking and the end of the run
  // ####################################################################
  task automatic load_patterns();
    int              fd;
    int              n;
    string           line;
    logic [31:0]     word;
    store_rec_t      rec;
    for (int i = 0; i < imem_words; i++) imem[i] = nop_word;
    for (int i = 0; i < dmem_words; i++) dmem[i] = 32'hd000_0000 | (i << 2);
    fd = $fopen("rv_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the patterns file rv_patterns.txt");
      load_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
      if (line[0] == "I" && prog_words < imem_words) begin
        n = $sscanf(line, "I %h", word);
        if (n == 1) begin
          imem[prog_words] = word;
          prog_words++;
        end else begin
          $display("Program line without an instruction word: %s", line);
          load_errors++;
        end
      end else if (line[0] == "S") begin
        n = $sscanf(line, "S %h %h %s", rec.addr, rec.data, rec.test_name);
        if (n == 3) begin
          expected.push_back(rec);
        end else begin
          $display("Store line without address, data and test name: %s", line);
          load_errors++;
        end
      end else begin
        $display("Patterns file line not understood: %s", line);
        load_errors++;
      end
    end
    $fclose(fd);
    if (expected.size() == 0) begin
      $display("The patterns file holds no expected stores");
      load_errors++;
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    store_rec_t rec;
    if (stores_seen >= expected.size()) begin
      $display("Surplus store of %h to address %h after all %0d expected stores",
               data, addr, expected.size());
      store_errors++;
    end else begin
      rec = expected[stores_seen];
      if (addr != rec.addr) begin
        $display("[ERROR] %0s: store address expected %h, actual %h", rec.test_name,
                 rec.addr, addr);
        store_errors++;
      end
      if (data != rec.data) begin
        $display("[ERROR] %0s: store data expected %h, actual %h", rec.test_name,
                 rec.data, data);
        store_errors++;
      end
    end
    stores_seen++;
  endtask

  task automatic report_and_finish();
    int total;
    total = load_errors + reset_errors + store_errors + int'(timed_out) +
            int'(UUT.u_props.fail_count);
    $display("Stores %0d of %0d, pattern errors %0d, reset errors %0d, store errors %0d, %s",
             stores_seen, expected.size(), load_errors, reset_errors, store_errors,
             $sformatf("timeouts %0d, assertion failures %0d", timed_out,
                       UUT.u_props.fail_count));
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Each store strobe lasts one cycle, so exactly one falling edge sees it
  always @(negedge clk) begin
    if (!rst_n) begin
      if (data_we) begin
        $display("Store strobe high during reset");
        store_errors++;
      end
    end else if (data_we) begin
      check_store(data_addr, data_wdata);
    end
  end

  initial begin : main_sequence
    rst_n = 1'b0;
    load_patterns();
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (instr_addr !== 32'h0) begin
      $display("[ERROR] reset_pc: instruction address expected %h, actual %h", 32'h0,
               instr_addr);
      reset_errors++;
    end
    rst_n = 1'b1;
    while (stores_seen < expected.size()) begin
      @(negedge clk);
    end
    repeat (drain_cycles) @(negedge clk);
    report_and_finish();
  end

  initial begin : watchdog
    @(posedge rst_n);
    repeat (prog_words * 5 + 50) @(posedge clk);
    $display("Timeout: only %0d of %0d expected stores arrived, the rest never came",
             stores_seen, expected.size());
    timed_out = 1'b1;
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: rv_core_properties.sv
`default_nettype none

module rv_core_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        data_we,
  input logic [31:0] data_addr,
  input logic        stall
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;  // Read by the testbench at the end of the run

  // The stage registers leave reset as bubbles, so the first edges see no store
  a_quiet_after_reset: assert property (@(posedge clk)
      (!rst_n || !$past(rst_n) || !$past(rst_n, 2) || !$past(rst_n, 3)) |-> !data_we)
    else begin
      fail_count++;
      $error("Store strobe high while reset bubbles are still in the pipeline");
    end

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      data_we |-> data_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("Store to an address that is not word aligned");
    end

  // A load-use hazard costs exactly one bubble
  a_single_stall: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
    else begin
      fail_count++;
      $error("Stall held high for two cycles in a row");
    end

endmodule

bind rv_core rv_core_properties u_props (
  .clk(clk), .rst_n(rst_n), .data_we(data_we), .data_addr(data_addr), .stall(stall)
);

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t instr_addr,
  input  word_t instr_data,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  input  word_t data_rdata
);

  fd_t fd_d, fd_q;
  de_t de_d, de_q;
  em_t em_d, em_q;
  mw_t mw_d, mw_q;

  word_t    pc;
  word_t    instr_dec;
  word_t    wb_value;
  word_t    branch_target;
  logic     branch_taken;
  logic     stall, flush_fetch, flush_decode;
  fwd_sel_e fwd_a, fwd_b;

  // ####################################################################
  // Fetch
  // ####################################################################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign instr_addr = pc;
  assign fd_d       = '{instr: instr_data, pc: pc, valid: 1'b1};

  rv_pipe_reg #(.payload_t(fd_t)) u_fd_reg (
    .clk(clk), .rst_n(rst_n), .enable(!stall), .flush(flush_fetch), .d(fd_d), .q(fd_q)
  );

  // ####################################################################
  // Decode
  // ####################################################################
  assign instr_dec = fd_q.valid ? fd_q.instr : nop_instr;
  assign de_d.pc   = fd_q.pc;

  rv_decoder u_decoder (
    .instr(instr_dec), .ctrl(de_d.ctrl), .rs1(de_d.rs1), .rs2(de_d.rs2), .rd(de_d.rd),
    .imm(de_d.imm)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .ra1(de_d.rs1), .ra2(de_d.rs2), .rd1(de_d.rd1),
    .rd2(de_d.rd2), .wa(mw_q.rd), .we(mw_q.reg_write), .wd(wb_value)
  );

  rv_hazard_unit u_hazard (
    .rs1_d(de_d.rs1), .rs2_d(de_d.rs2), .rs1_e(de_q.rs1), .rs2_e(de_q.rs2),
    .rd_e(de_q.rd), .rd_m(em_q.rd), .rd_w(mw_q.rd), .mem_to_reg_e(de_q.ctrl.mem_to_reg),
    .reg_write_m(em_q.reg_write), .reg_write_w(mw_q.reg_write),
    .branch_taken(branch_taken), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall),
    .flush_fetch(flush_fetch), .flush_decode(flush_decode)
  );

  rv_pipe_reg #(.payload_t(de_t)) u_de_reg (  // A stall turns into a bubble here
    .clk(clk), .rst_n(rst_n), .enable(1'b1), .flush(stall || flush_decode), .d(de_d),
    .q(de_q)
  );

  // ####################################################################
  // Execute, memory and writeback
  // ####################################################################
  rv_execute u_execute (
    .de(de_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(em_q.alu_result),
    .wb_result(wb_value), .em(em_d), .branch_taken(branch_taken),
    .branch_target(branch_target)
  );

  rv_pipe_reg #(.payload_t(em_t)) u_em_reg (
    .clk(clk), .rst_n(rst_n), .enable(1'b1), .flush(1'b0), .d(em_d), .q(em_q)
  );

  assign data_addr  = em_q.alu_result;
  assign data_wdata = em_q.write_data;
  assign data_we    = em_q.mem_write;

  assign mw_d = '{reg_write: em_q.reg_write, mem_to_reg: em_q.mem_to_reg,
                  alu_result: em_q.alu_result, read_data: data_rdata, rd: em_q.rd};

  rv_pipe_reg #(.payload_t(mw_t)) u_mw_reg (
    .clk(clk), .rst_n(rst_n), .enable(1'b1), .flush(1'b0), .d(mw_d), .q(mw_q)
  );

  assign wb_value = mw_q.mem_to_reg ? mw_q.read_data : mw_q.alu_result;

endmodule

`default_nettype wire

// File: rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  de_t      de,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  word_t    mem_result,
  input  word_t    wb_result,
  output em_t      em,
  output logic     branch_taken,
  output word_t    branch_target
);

  word_t      op_a;
  word_t      reg_b;  // Forwarded rs2, also the store data
  word_t      op_b;
  word_t      alu_y;
  logic [4:0] shamt;
  logic       cond;

  always_comb begin
    case (fwd_a)
      fwd_from_mem: op_a = mem_result;
      fwd_from_wb:  op_a = wb_result;
      default:      op_a = de.rd1;
    endcase
    case (fwd_b)
      fwd_from_mem: reg_b = mem_result;
      fwd_from_wb:  reg_b = wb_result;
      default:      reg_b = de.rd2;
    endcase
  end

  assign op_b  = de.ctrl.alu_src_imm ? de.imm : reg_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (de.ctrl.alu_op)
      alu_sub:    alu_y = op_a - op_b;
      alu_and:    alu_y = op_a & op_b;
      alu_or:     alu_y = op_a | op_b;
      alu_xor:    alu_y = op_a ^ op_b;
      alu_slt:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_y = {31'b0, op_a < op_b};
      alu_sll:    alu_y = op_a << shamt;
      alu_srl:    alu_y = op_a >> shamt;
      alu_sra:    alu_y = word_t'($signed(op_a) >>> shamt);
      alu_pass_b: alu_y = op_b;
      default:    alu_y = op_a + op_b;
    endcase
  end

  // Branches compare the two register operands directly
  always_comb begin
    case (de.ctrl.branch_funct)
      f3_beq:  cond = (op_a == reg_b);
      f3_bne:  cond = (op_a != reg_b);
      f3_blt:  cond = ($signed(op_a) < $signed(reg_b));
      f3_bge:  cond = ($signed(op_a) >= $signed(reg_b));
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken  = de.ctrl.is_branch && cond;
  assign branch_target = de.pc + de.imm;

  assign em.reg_write  = de.ctrl.reg_write;
  assign em.mem_write  = de.ctrl.mem_write;
  assign em.mem_to_reg = de.ctrl.mem_to_reg;
  assign em.alu_result = alu_y;
  assign em.write_data = reg_b;
  assign em.rd         = de.rd;

endmodule

`default_nettype wire

// File: rv_hazard_unit.sv
`default_nettype none

module rv_hazard_unit import rv_pkg::*; (
  input  reg_idx_t rs1_d,
  input  reg_idx_t rs2_d,
  input  reg_idx_t rs1_e,
  input  reg_idx_t rs2_e,
  input  reg_idx_t rd_e,
  input  reg_idx_t rd_m,
  input  reg_idx_t rd_w,
  input  logic     mem_to_reg_e,
  input  logic     reg_write_m,
  input  logic     reg_write_w,
  input  logic     branch_taken,
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b,
  output logic     stall,
  output logic     flush_fetch,
  output logic     flush_decode
);

  // Memory stage holds the younger result, so it is checked first
  function automatic fwd_sel_e fwd_pick(input reg_idx_t rs, input reg_idx_t rdm,
                                        input logic wm, input reg_idx_t rdw, input logic ww);
    if (rs != '0 && wm && rs == rdm) return fwd_from_mem;
    if (rs != '0 && ww && rs == rdw) return fwd_from_wb;
    return fwd_none;
  endfunction

  assign fwd_a = fwd_pick(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
  assign fwd_b = fwd_pick(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

  assign stall        = mem_to_reg_e && (rd_e == rs1_d || rd_e == rs2_d);  // Load-use
  assign flush_fetch  = branch_taken;
  assign flush_decode = branch_taken;

endmodule

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  output word_t    rd1,
  output word_t    rd2,
  input  reg_idx_t wa,
  input  logic     we,
  input  word_t    wd
);

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // A read of the register being written sees the new value in the same cycle
  assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// File: rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t    instr,
  output ctrl_t    ctrl,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;  // funct7 bit 5 selects sub and sra

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt_bit,
                                         input logic is_reg);
    case (f3)
      3'b000:  return (is_reg && alt_bit) ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt_bit ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[30];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    ctrl = '0;  // Anything not matched below falls through as a nop
    imm  = '0;
    case (opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, alt, 1'b1);
      end
      op_imm: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_decode(funct3, alt, 1'b0);
        imm              = {{20{instr[31]}}, instr[31:20]};
      end
      op_load: if (funct3 == f3_word) begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:20]};
      end
      op_store: if (funct3 == f3_word) begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      op_branch: if (funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge}) begin
        ctrl.is_branch    = 1'b1;
        ctrl.branch_funct = funct3;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      op_lui: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_pass_b;
        imm              = {instr[31:12], 12'b0};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_pipe_reg.sv
`default_nettype none

// One stage register shared by all four pipeline boundaries
module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enable,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (flush) begin  // Wins over enable so a frozen stage can still be emptied
      q <= '0;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ####################################################################
  // Widths and base types
  // ####################################################################
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_lui    = 7'b0110111;

  localparam logic [2:0] f3_word = 3'b010;  // Only lw and sw are kept
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;

  // alu_add must stay at zero so that an all-zero control word is harmless
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {fwd_none, fwd_from_mem, fwd_from_wb} fwd_sel_e;

  // ####################################################################
  // Control word and stage payloads, all-zero is a bubble everywhere
  // ####################################################################
  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    logic       mem_to_reg;
    logic       alu_src_imm;
    logic       is_branch;
    logic [2:0] branch_funct;
    alu_op_e    alu_op;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
    logic  valid;
  } fd_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    rd1;
    word_t    rd2;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    pc;
  } de_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_write;
    logic     mem_to_reg;
    word_t    alu_result;
    word_t    write_data;
    reg_idx_t rd;
  } em_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    word_t    alu_result;
    word_t    read_data;
    reg_idx_t rd;
  } mw_t;

endpackage

`default_nettype wire
